// File: t2_bus_pkg.sv
//===========================================================================
// shared map constants and bus types for the Truxton II main-CPU glue
// word addresses throughout; byte offsets only where noted
// banks must sit on a boundary of their own size
//===========================================================================
package t2_bus_pkg;

    localparam int adr_w   = 23;       // word address, byte bit 0 dropped
    localparam int dat_w   = 16;
    localparam int n_banks = 4;

    // palette, text vram, line-select, line-scroll
    localparam int bank_aw [n_banks] = '{11, 12, 11, 8};
    localparam logic [adr_w-1:0] bank_base [n_banks] = '{
        23'h180000,                    // byte 0x300000
        23'h200000,                    // byte 0x400000
        23'h201000,                    // byte 0x402000
        23'h201800                     // byte 0x403000
    };

    localparam logic [3:0]  rgn_gcu    = 4'h2;
    localparam logic [3:0]  rgn_vcount = 4'h6;
    localparam logic [3:0]  rgn_io     = 4'h7;
    localparam logic [10:0] io_page    = {rgn_io, 7'h00};   // 0x380

    // i/o registers, byte offsets inside the page
    localparam logic [12:0] io_dsw_a = 13'h000;
    localparam logic [12:0] io_dsw_b = 13'h002;
    localparam logic [12:0] io_jmpr  = 13'h004;
    localparam logic [12:0] io_p1    = 13'h006;
    localparam logic [12:0] io_p2    = 13'h008;
    localparam logic [12:0] io_sys   = 13'h00A;

    // gcu registers, low byte-address nibble
    localparam logic [3:0] gcu_ram_ptr = 4'h0;
    localparam logic [3:0] gcu_ram_h   = 4'h4;
    localparam logic [3:0] gcu_ram_l   = 4'h6;
    localparam logic [3:0] gcu_select  = 4'h8;
    localparam logic [3:0] gcu_wreg    = 4'hC;   // blanking on reads

    typedef struct packed {
        logic [3:0]       region;
        logic [adr_w-5:0] ofs;
    } adr_rgn_t;

    typedef struct packed {
        logic [10:0] page;
        logic [11:0] rfield;
    } adr_page_t;

    typedef union packed {
        adr_rgn_t  rgn;                // bank ranges, gcu, vcount
        adr_page_t pg;                 // i/o page
    } bus_adr_u;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        bus_adr_u         adr;
        logic [1:0]       sel;
        logic [dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [dat_w-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [n_banks-1:0] bank;
        logic               gcu;
        logic               vcount;
        logic               io;
        logic               none;
        logic               we;
        logic [1:0]         sel;
        logic [11:0]        rfield;   // bank word address or register
    } bus_sel_t;

    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dsw_a;
        logic [7:0] dsw_b;
        logic [7:0] dsw_c;
    } cab_in_t;

    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

endpackage

// File: t2_addr_decode.sv
//===========================================================================
// captures one Wishbone access and decodes it to one-hot selects
// hit bits last a single cycle; payload fields hold until next capture
//===========================================================================
`timescale 1ns/1ns

module t2_addr_decode (
    input  logic                 clk96,
    input  logic                 reset96,
    input  t2_bus_pkg::wb_req_t  req,
    input  logic                 busy,
    output t2_bus_pkg::bus_sel_t sel_q,
    output logic [15:0]          wdat
);

    t2_bus_pkg::bus_sel_t nxt;
    logic                 take;

    assign take = req.cyc && req.stb && !busy;

    always_comb begin
        nxt        = '0;
        nxt.we     = req.we;
        nxt.sel    = req.sel;
        nxt.rfield = req.adr.pg.rfield;
        for (int i = 0; i < t2_bus_pkg::n_banks; i++) begin
            nxt.bank[i] = (req.adr.rgn.region == t2_bus_pkg::bank_base[i][22:19]) &&
                          ((req.adr.rgn.ofs >> t2_bus_pkg::bank_aw[i]) ==
                           (t2_bus_pkg::bank_base[i][18:0] >> t2_bus_pkg::bank_aw[i]));
        end
        nxt.gcu    = req.adr.rgn.region == t2_bus_pkg::rgn_gcu;
        nxt.vcount = req.adr.rgn.region == t2_bus_pkg::rgn_vcount;
        nxt.io     = req.adr.pg.page == t2_bus_pkg::io_page;
        nxt.none   = !(|nxt.bank || nxt.gcu || nxt.vcount || nxt.io);
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sel_q <= '0;
        end else if (take) begin
            sel_q <= nxt;
        end else begin
            // hits pulse once, the rest stays for the banks
            sel_q.bank   <= '0;
            sel_q.gcu    <= 1'b0;
            sel_q.vcount <= 1'b0;
            sel_q.io     <= 1'b0;
            sel_q.none   <= 1'b0;
        end
    end

    always_ff @(posedge clk96) begin
        if (take)
            wdat <= req.dat;
    end

endmodule

// File: t2_vram_bank.sv
//===========================================================================
// one dual-port video RAM bank, 2**aw words of 16 bits
// cpu port reads old data on a write; video port is read only
//===========================================================================
`timescale 1ns/1ns

module t2_vram_bank #(
    parameter int aw = 11
) (
    input  logic                 clk96,
    input  t2_bus_pkg::bus_sel_t sel_q,
    input  logic                 hit,
    input  logic [15:0]          wdat,
    output logic [15:0]          cpu_q,
    input  logic [aw-1:0]        vid_addr,
    output logic [15:0]          vid_q
);

    logic [15:0]   mem [2**aw];
    logic [aw-1:0] cpu_addr;

    assign cpu_addr = sel_q.rfield[aw-1:0];   // bank is size aligned

    always_ff @(posedge clk96) begin
        if (hit) begin
            cpu_q <= mem[cpu_addr];
            if (sel_q.we && sel_q.sel[0])
                mem[cpu_addr][7:0] <= wdat[7:0];
            if (sel_q.we && sel_q.sel[1])
                mem[cpu_addr][15:8] <= wdat[15:8];
        end
    end

    // video side, one cycle latency
    always_ff @(posedge clk96) begin
        vid_q <= mem[vid_addr];
    end

endmodule

// File: t2_cabinet_io.sv
//===========================================================================
// cabinet input words and the video status word
// joystick and buttons arrive active high and leave active low
// only the video status word is registered
//===========================================================================
`timescale 1ns/1ns

module t2_cabinet_io (
    input  logic                clk96,
    input  logic                reset96,
    input  t2_bus_pkg::cab_in_t cab,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                fblank,
    input  logic [8:0]          v,
    output logic [15:0]         dsw_a,
    output logic [15:0]         dsw_b,
    output logic [15:0]         jmpr,
    output logic [15:0]         p1,
    output logic [15:0]         p2,
    output logic [15:0]         sys,
    output logic [15:0]         vstatus
);

    logic [7:0]  sys_lo;
    logic [15:0] vs_next;

    // up, down, left, right, then buttons 1..3
    function automatic logic [7:0] joy_byte(input logic [9:0] j);
        joy_byte = {1'b0, ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    assign dsw_a = {2{cab.dsw_a}};
    assign dsw_b = {2{cab.dsw_b}};
    assign jmpr  = {2{cab.dsw_c}};
    assign p1    = {2{joy_byte(cab.joy1)}};
    assign p2    = {2{joy_byte(cab.joy2)}};

    assign sys_lo = {1'b0, ~cab.start[1], ~cab.start[0], ~cab.coin[1], ~cab.coin[0],
                     ~cab.test, 1'b0, ~cab.service};
    assign sys    = {cab.dsw_c, sys_lo};

    always_comb begin
        vs_next       = 16'hFF00;
        vs_next[15]   = hsync;
        vs_next[14]   = vsync;
        vs_next[8]    = fblank;
        vs_next[7:0]  = v[8] ? 8'hFF : v[7:0];   // saturate past line 255
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96)
            vstatus <= 16'h0000;
        else
            vstatus <= vs_next;
    end

endmodule

// File: t2_gcu_strobe.sv
//===========================================================================
// GCU operation strobes, held until the GCU acknowledges
// offsets with no operation finish at once without a strobe
//===========================================================================
`timescale 1ns/1ns

module t2_gcu_strobe (
    input  logic                 clk96,
    input  logic                 reset96,
    input  t2_bus_pkg::bus_sel_t sel_q,
    input  logic                 gcu_ack,
    input  logic [15:0]          gcu_dout,
    output t2_bus_pkg::gcu_op_t  op,
    output logic                 done,
    output logic [15:0]          rdat
);

    t2_bus_pkg::gcu_op_t dec;
    logic [3:0]          ofs;
    logic                acked;

    assign ofs   = {sel_q.rfield[2:0], 1'b0};   // byte nibble
    assign acked = (|op) && gcu_ack;

    always_comb begin
        dec = '0;
        if (!sel_q.we) begin
            dec.read_ram_h = ofs == t2_bus_pkg::gcu_ram_h;
            dec.read_ram_l = ofs == t2_bus_pkg::gcu_ram_l;
        end else begin
            case (ofs)
                t2_bus_pkg::gcu_wreg:    dec.write_reg   = 1'b1;
                t2_bus_pkg::gcu_select:  dec.select_reg  = 1'b1;
                t2_bus_pkg::gcu_ram_h,
                t2_bus_pkg::gcu_ram_l:   dec.write_ram   = 1'b1;
                t2_bus_pkg::gcu_ram_ptr: dec.set_ram_ptr = 1'b1;
                default:                 dec             = '0;
            endcase
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            op   <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (sel_q.gcu) begin
                op   <= dec;
                done <= dec == '0;   // nothing to wait for
            end else if (acked) begin
                op   <= '0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk96) begin
        if (acked)
            rdat <= gcu_dout;
    end

endmodule

// File: t2_read_mux.sv
//===========================================================================
// read data select, dat_r register and the single ack per access
// plain accesses ack two edges after capture, GCU ones after done
//===========================================================================
`timescale 1ns/1ns

module t2_read_mux #(
    parameter int nb = 4
) (
    input  logic                  clk96,
    input  logic                  reset96,
    input  t2_bus_pkg::bus_sel_t  sel_q,
    input  logic [nb-1:0][15:0]   bank_q,
    input  logic [15:0]           dsw_a,
    input  logic [15:0]           dsw_b,
    input  logic [15:0]           jmpr,
    input  logic [15:0]           p1,
    input  logic [15:0]           p2,
    input  logic [15:0]           sys,
    input  logic [15:0]           vstatus,
    input  logic                  gcu_done,
    input  logic [15:0]           gcu_rdat,
    input  logic                  lvbl,
    output t2_bus_pkg::wb_rsp_t   rsp,
    output logic                  busy
);

    t2_bus_pkg::bus_sel_t cur;
    logic                 pend;
    logic                 new_acc;
    logic [15:0]          rd;

    assign new_acc = |sel_q.bank || sel_q.gcu || sel_q.vcount || sel_q.io || sel_q.none;
    assign busy    = new_acc || pend || rsp.ack;   // covers capture to ack

    always_comb begin
        rd = 16'h0000;   // writes and unmapped
        if (!cur.we) begin
            for (int i = 0; i < nb; i++) begin
                if (cur.bank[i])
                    rd = bank_q[i];
            end
            if (cur.vcount)
                rd = vstatus;
            if (cur.io) begin
                case ({cur.rfield, 1'b0})
                    t2_bus_pkg::io_dsw_a: rd = dsw_a;
                    t2_bus_pkg::io_dsw_b: rd = dsw_b;
                    t2_bus_pkg::io_jmpr:  rd = jmpr;
                    t2_bus_pkg::io_p1:    rd = p1;
                    t2_bus_pkg::io_p2:    rd = p2;
                    t2_bus_pkg::io_sys:   rd = sys;
                    default:              rd = 16'h0000;
                endcase
            end
            if (cur.gcu) begin
                case ({cur.rfield[2:0], 1'b0})
                    t2_bus_pkg::gcu_ram_h,
                    t2_bus_pkg::gcu_ram_l: rd = gcu_rdat;
                    t2_bus_pkg::gcu_wreg:  rd = {15'h0000, ~lvbl};   // blanking
                    default:               rd = 16'h0000;
                endcase
            end
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            rsp  <= '0;
            pend <= 1'b0;
            cur  <= '0;
        end else begin
            rsp.ack <= 1'b0;
            if (new_acc) begin
                cur  <= sel_q;
                pend <= 1'b1;
            end else if (pend && (!cur.gcu || gcu_done)) begin
                pend    <= 1'b0;
                rsp.ack <= 1'b1;
                rsp.dat <= rd;
            end
        end
    end

endmodule

// File: t2_main_bus.sv
//===========================================================================
// main-CPU bus glue, Wishbone classic slave, Truxton II map
// video addresses are 12 bits per bank, upper bits ignored on small banks
// master must hold a request until ack and drop stb for a cycle after
//===========================================================================
`timescale 1ns/1ns

module t2_main_bus (
    input  logic                                 clk96,
    input  logic                                 reset96,
    input  t2_bus_pkg::wb_req_t                  wb_req,
    output t2_bus_pkg::wb_rsp_t                  wb_rsp,
    input  t2_bus_pkg::cab_in_t                  cab,
    input  logic                                 hsync,
    input  logic                                 vsync,
    input  logic                                 fblank,
    input  logic                                 lvbl,
    input  logic [8:0]                           v,
    input  logic                                 gcu_ack,
    input  logic [15:0]                          gcu_dout,
    output t2_bus_pkg::gcu_op_t                  gcu_op,
    input  logic [t2_bus_pkg::n_banks-1:0][11:0] vid_addr,
    output logic [t2_bus_pkg::n_banks-1:0][15:0] vid_q
);

    t2_bus_pkg::bus_sel_t               sel_q;
    logic [15:0]                        wdat;
    logic                               busy;
    logic [t2_bus_pkg::n_banks-1:0][15:0] bank_q;
    logic [15:0]                        dsw_a, dsw_b, jmpr, p1, p2, sys, vstatus;
    logic                               gcu_done;
    logic [15:0]                        gcu_rdat;

    t2_addr_decode u_decode (
        .clk96   (clk96),
        .reset96 (reset96),
        .req     (wb_req),
        .busy    (busy),
        .sel_q   (sel_q),
        .wdat    (wdat)
    );

    for (genvar i = 0; i < t2_bus_pkg::n_banks; i++) begin : g_bank
        localparam int aw = t2_bus_pkg::bank_aw[i];

        t2_vram_bank #(.aw(aw)) u_bank (
            .clk96    (clk96),
            .sel_q    (sel_q),
            .hit      (sel_q.bank[i]),
            .wdat     (wdat),
            .cpu_q    (bank_q[i]),
            .vid_addr (vid_addr[i][aw-1:0]),
            .vid_q    (vid_q[i])
        );
    end

    t2_cabinet_io u_cab (
        .clk96   (clk96),
        .reset96 (reset96),
        .cab     (cab),
        .hsync   (hsync),
        .vsync   (vsync),
        .fblank  (fblank),
        .v       (v),
        .dsw_a   (dsw_a),
        .dsw_b   (dsw_b),
        .jmpr    (jmpr),
        .p1      (p1),
        .p2      (p2),
        .sys     (sys),
        .vstatus (vstatus)
    );

    t2_gcu_strobe u_gcu (
        .clk96    (clk96),
        .reset96  (reset96),
        .sel_q    (sel_q),
        .gcu_ack  (gcu_ack),
        .gcu_dout (gcu_dout),
        .op       (gcu_op),
        .done     (gcu_done),
        .rdat     (gcu_rdat)
    );

    t2_read_mux #(.nb(t2_bus_pkg::n_banks)) u_rmux (
        .clk96    (clk96),
        .reset96  (reset96),
        .sel_q    (sel_q),
        .bank_q   (bank_q),
        .dsw_a    (dsw_a),
        .dsw_b    (dsw_b),
        .jmpr     (jmpr),
        .p1       (p1),
        .p2       (p2),
        .sys      (sys),
        .vstatus  (vstatus),
        .gcu_done (gcu_done),
        .gcu_rdat (gcu_rdat),
        .lvbl     (lvbl),
        .rsp      (wb_rsp),
        .busy     (busy)
    );

endmodule

// File: t2_main_bus_asserts.sv
//===========================================================================
// Wishbone ack and GCU strobe rules, bound onto the bus top level
// all checks are off while reset96 is high
//===========================================================================
`timescale 1ns/1ns

module t2_main_bus_asserts (
    input logic                clk96,
    input logic                reset96,
    input t2_bus_pkg::wb_req_t wb_req,
    input t2_bus_pkg::wb_rsp_t wb_rsp,
    input t2_bus_pkg::gcu_op_t gcu_op
);

    int fails = 0;

    // ack only inside an open cycle
    ack_in_cycle: assert property (@(posedge clk96) disable iff (reset96)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fails++;
            $error("ack seen without cyc and stb");
        end

    ack_single: assert property (@(posedge clk96) disable iff (reset96)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fails++;
            $error("ack high on two cycles in a row");
        end

    gcu_op_onehot: assert property (@(posedge clk96) disable iff (reset96)
        $onehot0(gcu_op))
        else begin
            fails++;
            $error("more than one GCU strobe high");
        end

endmodule

// File: tb_t2_main_bus.sv
//===========================================================================
// directed testbench for the main bus glue, Wishbone master model
// the testbench plays the GCU by driving gcu_ack and gcu_dout
// a watchdog ends the run if an ack never arrives
//===========================================================================
`timescale 1ns/1ns

module tb_t2_main_bus;

    localparam int words_per_bank = 8;
    localparam int cab_rounds     = 4;
    localparam int access_cycles  = 6;   // start, E0..E2, drop, slack
    localparam int test_cycles    = 16 + 2
        + t2_bus_pkg::n_banks * words_per_bank * (3 * access_cycles + 3)
        + cab_rounds * (3 + 7 * access_cycles)
        + 2 * (6 + 8 + access_cycles) + 4 * access_cycles + 8;
    localparam int timeout_ns     = test_cycles * 4 + 1000;

    // bank base byte addresses and word offset masks
    localparam logic [23:0] bank_byte [4] = '{24'h300000, 24'h400000, 24'h402000, 24'h403000};
    localparam logic [11:0] bank_mask [4] = '{12'h7FF, 12'hFFF, 12'h7FF, 12'h0FF};

    logic                                 clk96 = 1'b0;
    logic                                 reset96;
    t2_bus_pkg::wb_req_t                  wb_req;
    t2_bus_pkg::wb_rsp_t                  wb_rsp;
    t2_bus_pkg::cab_in_t                  cab;
    logic                                 hsync, vsync, fblank, lvbl;
    logic [8:0]                           v;
    logic                                 gcu_ack;
    logic [15:0]                          gcu_dout;
    t2_bus_pkg::gcu_op_t                  gcu_op;
    logic [t2_bus_pkg::n_banks-1:0][11:0] vid_addr;
    logic [t2_bus_pkg::n_banks-1:0][15:0] vid_q;
    int                                   seed = 32'h8f7a7855;
    int                                   errors = 0;
    int                                   checks = 0;

    t2_main_bus DUT (
        .clk96 (clk96), .reset96 (reset96), .wb_req (wb_req), .wb_rsp (wb_rsp),
        .cab (cab), .hsync (hsync), .vsync (vsync), .fblank (fblank), .lvbl (lvbl),
        .v (v), .gcu_ack (gcu_ack), .gcu_dout (gcu_dout), .gcu_op (gcu_op),
        .vid_addr (vid_addr), .vid_q (vid_q)
    );

    bind t2_main_bus t2_main_bus_asserts u_asserts (
        .clk96 (clk96), .reset96 (reset96), .wb_req (wb_req), .wb_rsp (wb_rsp),
        .gcu_op (gcu_op)
    );

    always #2 clk96 = ~clk96;

    initial begin
        #(timeout_ns);
        $display("timeout: the DUT gave no ack within %0d ns", timeout_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_eq(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    function automatic logic [22:0] word_of(input logic [23:0] byte_adr);
        return byte_adr[23:1];
    endfunction

    // joystick bits 0 right, 1 left, 2 down, 3 up, 4..6 buttons
    function automatic logic [15:0] joy_word(input logic [9:0] j);
        logic [7:0] b;
        b      = 8'h00;
        b[0]   = ~j[3];   // up
        b[1]   = ~j[2];   // down
        b[2]   = ~j[1];   // left
        b[3]   = ~j[0];   // right
        b[6:4] = ~j[6:4];
        return {b, b};
    endfunction

    function automatic logic [15:0] sys_word(input t2_bus_pkg::cab_in_t c);
        logic [7:0] b;
        b    = 8'h00;
        b[0] = ~c.service;
        b[2] = ~c.test;
        b[3] = ~c.coin[0];
        b[4] = ~c.coin[1];
        b[5] = ~c.start[0];
        b[6] = ~c.start[1];
        return {c.dsw_c, b};
    endfunction

    function automatic logic [15:0] status_word(input logic hs, input logic vs,
                                                input logic fb, input logic [8:0] vc);
        logic [15:0] w;
        w       = 16'hFF00;
        w[15]   = hs;
        w[14]   = vs;
        w[8]    = fb;
        w[7:0]  = (vc < 9'd256) ? vc[7:0] : 8'hFF;
        return w;
    endfunction

    task automatic start_access(input logic we, input logic [22:0] adr,
                                input logic [1:0] sel, input logic [15:0] dat);
        @(posedge clk96);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= t2_bus_pkg::bus_adr_u'(adr);
        wb_req.sel <= sel;
        wb_req.dat <= dat;
    endtask

    // edges counted from the first one that samples stb
    task automatic wait_ack(output int edges, output logic [15:0] dat);
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            @(posedge clk96);
            edges++;
            @(negedge clk96);
            seen = wb_rsp.ack;
        end
        dat = wb_rsp.dat;
    endtask

    task automatic end_access();
        @(posedge clk96);   // edge that samples ack
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [22:0] adr, input logic [1:0] sel,
                            input logic [15:0] dat);
        int          edges;
        logic [15:0] d;
        start_access(1'b1, adr, sel, dat);
        wait_ack(edges, d);
        check_eq("write ack latency", 16'(edges - 1), 16'd2);
        end_access();
    endtask

    task automatic wb_read(input logic [22:0] adr, output logic [15:0] dat);
        int edges;
        start_access(1'b0, adr, 2'b11, 16'h0000);
        wait_ack(edges, dat);
        check_eq("read ack latency", 16'(edges - 1), 16'd2);
        end_access();
    endtask

    task automatic read_and_compare(input string name, input logic [22:0] adr,
                                    input logic [15:0] exp);
        logic [15:0] d;
        wb_read(adr, d);
        check_eq(name, d, exp);
    endtask

    task automatic reset_values();
        @(negedge clk96);
        check_eq("wb_rsp.ack", {15'h0000, wb_rsp.ack}, 16'h0000);
        check_eq("wb_rsp.dat", wb_rsp.dat, 16'h0000);
        check_eq("gcu_op", {10'h000, gcu_op}, 16'h0000);
    endtask

    task automatic bank_readback();
        logic [15:0] shadow [4096];
        logic [11:0] used [$];
        logic [31:0] rnd;
        logic [11:0] ofs;
        for (int b = 0; b < t2_bus_pkg::n_banks; b++) begin
            used.delete();
            for (int k = 0; k < words_per_bank; k++) begin
                rnd = $random(seed);
                ofs = rnd[11:0] & bank_mask[b];
                shadow[ofs] = rnd[31:16];
                wb_write(word_of(bank_byte[b]) | {11'h000, ofs}, 2'b11, rnd[31:16]);
                used.push_back(ofs);
            end
            // random byte selects leave the unselected lane as it was
            foreach (used[k]) begin
                rnd = $random(seed);
                wb_write(word_of(bank_byte[b]) | {11'h000, used[k]}, rnd[17:16], rnd[15:0]);
                if (rnd[16])
                    shadow[used[k]][7:0] = rnd[7:0];
                if (rnd[17])
                    shadow[used[k]][15:8] = rnd[15:8];
            end
            foreach (used[k]) begin
                read_and_compare($sformatf("bank%0d word %h", b, used[k]),
                                 word_of(bank_byte[b]) | {11'h000, used[k]}, shadow[used[k]]);
                @(posedge clk96);
                vid_addr[b] <= used[k];
                @(posedge clk96);
                @(negedge clk96);
                check_eq($sformatf("vid_q[%0d]", b), vid_q[b], shadow[used[k]]);
            end
        end
    endtask

    task automatic cabinet_words();
        t2_bus_pkg::cab_in_t c;
        logic [31:0]         r1, r2, r3;
        logic [8:0]          vc;
        for (int r = 0; r < cab_rounds; r++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            c  = t2_bus_pkg::cab_in_t'({r3[31:10], r1});
            vc = r2[29:21];
            if (r == 0)
                vc[8] = 1'b0;   // visible line
            if (r == 1)
                vc[8] = 1'b1;   // count saturates
            @(posedge clk96);
            cab    <= c;
            v      <= vc;
            hsync  <= r2[30];
            vsync  <= r2[31];
            fblank <= r3[0];
            repeat (2) @(posedge clk96);   // status word is registered
            read_and_compare("dsw_a", word_of(24'h700000), {c.dsw_a, c.dsw_a});
            read_and_compare("dsw_b", word_of(24'h700002), {c.dsw_b, c.dsw_b});
            read_and_compare("jumper", word_of(24'h700004), {c.dsw_c, c.dsw_c});
            read_and_compare("p1", word_of(24'h700006), joy_word(c.joy1));
            read_and_compare("p2", word_of(24'h700008), joy_word(c.joy2));
            read_and_compare("system", word_of(24'h70000A), sys_word(c));
            read_and_compare("vstatus", word_of(24'h600000),
                             status_word(r2[30], r2[31], r3[0], vc));
        end
    endtask

    // strobe holds until gcu_ack and ack follows one edge later
    task automatic gcu_strobed_access(input logic we, input logic [23:0] byte_adr,
                                      input t2_bus_pkg::gcu_op_t exp_op,
                                      input logic [15:0] dout, output logic [15:0] rdat);
        int edges;
        start_access(we, word_of(byte_adr), 2'b11, dout ^ 16'h5A5A);
        repeat (2) @(posedge clk96);   // E0 capture, E1 strobe
        for (int i = 0; i < 4; i++) begin
            @(negedge clk96);
            check_eq("gcu_op held", {10'h000, gcu_op}, {10'h000, exp_op});
            check_eq("wb_rsp.ack before gcu_ack", {15'h0000, wb_rsp.ack}, 16'h0000);
            @(posedge clk96);
        end
        gcu_ack  <= 1'b1;
        gcu_dout <= dout;
        @(posedge clk96);
        gcu_ack  <= 1'b0;
        gcu_dout <= ~dout;
        @(negedge clk96);
        check_eq("gcu_op after gcu_ack", {10'h000, gcu_op}, 16'h0000);
        check_eq("wb_rsp.ack at gcu_ack", {15'h0000, wb_rsp.ack}, 16'h0000);
        wait_ack(edges, rdat);
        check_eq("ack edges after gcu_ack", 16'(edges), 16'd1);
        end_access();
    endtask

    task automatic gcu_handshake();
        t2_bus_pkg::gcu_op_t exp_op;
        logic [31:0]         rnd;
        logic [15:0]         rdat;
        rnd               = $random(seed);
        exp_op            = '0;
        exp_op.select_reg = 1'b1;
        gcu_strobed_access(1'b1, 24'h200008, exp_op, rnd[15:0], rdat);
        exp_op            = '0;
        exp_op.read_ram_h = 1'b1;
        gcu_strobed_access(1'b0, 24'h200004, exp_op, rnd[31:16], rdat);
        check_eq("gcu ram high read", rdat, rnd[31:16]);
    endtask

    task automatic status_and_unmapped();
        for (int i = 0; i < 2; i++) begin
            @(posedge clk96);
            lvbl <= i[0];
            read_and_compare("gcu blanking", word_of(24'h20000C), {15'h0000, ~i[0]});
        end
        wb_write(word_of(24'h500000), 2'b11, 16'hFFFF);
        read_and_compare("unmapped read", word_of(24'h500000), 16'h0000);
    endtask

    initial begin
        reset96  <= 1'b1;
        wb_req   <= '0;
        cab      <= '0;
        hsync    <= 1'b0;
        vsync    <= 1'b0;
        fblank   <= 1'b0;
        lvbl     <= 1'b0;
        v        <= 9'h000;
        gcu_ack  <= 1'b0;
        gcu_dout <= 16'h0000;
        vid_addr <= '0;
        repeat (16) @(posedge clk96);
        reset96 <= 1'b0;
        reset_values();
        bank_readback();
        cabinet_words();
        gcu_handshake();
        status_and_unmapped();
        repeat (4) @(posedge clk96);
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, DUT.u_asserts.fails);
        if (errors == 0 && DUT.u_asserts.fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
t2_bus_pkg.sv
t2_addr_decode.sv
t2_vram_bank.sv
t2_cabinet_io.sv
t2_gcu_strobe.sv
t2_read_mux.sv
t2_main_bus.sv
t2_main_bus_asserts.sv
tb_t2_main_bus.sv

// File: Makefile
# Verilator build and run for the Truxton II main bus testbench

VERILATOR ?= verilator
TOP       ?= tb_t2_main_bus
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
